/* design/ndn_pkg.sv */
package ndn_pkg;

	// Name as carried by interests and data packets
	typedef struct packed {
		logic [63:0] prefix;
		logic [5:0]  length;  // Name length in components
	} ndn_name_t;

	// Interest view of the metadata word
	typedef struct packed {
		logic [1:0] kind;
		logic [5:0] length;
	} pit_meta_interest_t;

	// Data view of the same word, bit 6 is the repeat flag here
	typedef struct packed {
		logic       forwarded;
		logic       again;
		logic [5:0] face;
	} pit_meta_data_t;

	typedef union packed {
		pit_meta_interest_t interest;
		pit_meta_data_t     data;
	} pit_meta_u;

	localparam logic [1:0] KIND_INTEREST = 2'b01;

	// One FIB route
	typedef struct packed {
		logic [63:0] prefix;
		logic [6:0]  match_len;  // Leading bits compared, 0 to 64
		logic [5:0]  face;
	} route_t;

	// PIT slot contents
	typedef struct packed {
		logic       valid;
		logic       data_seen;
		logic [9:0] addr;       // Content buffer row
	} pit_entry_t;

	// What the PIT reports on result_valid
	typedef struct packed {
		logic       data_seen;
		logic [9:0] addr;
		pit_meta_u  meta;
	} pit_result_t;

endpackage

/* design/name_hash.sv */
`timescale 1ns/100ps

module name_hash (
	input  logic        clk,
	input  logic        rst,
	input  logic [63:0] pre_hash,
	output logic [5:0]  slot
);

	logic [5:0] fold;

	// XOR of the ten 6-bit slices plus the top nibble
	always_comb begin
		fold = {2'b00, pre_hash[63:60]};
		for (int i = 0; i < 10; i++) begin
			fold = fold ^ pre_hash[i*6 +: 6];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			slot <= '0;
		end else begin
			slot <= fold;  // Ready one edge after pre_hash
		end
	end

endmodule

/* design/fib_table.sv */
`timescale 1ns/100ps

module fib_table import ndn_pkg::*; #(
	parameter int FIB_ENTRIES = 8
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           route_wr,
	input  logic [$clog2(FIB_ENTRIES)-1:0] route_index,
	input  route_t                         route,
	input  logic                           data_strobe,
	input  ndn_name_t                      data_name,
	input  logic                           data_again,
	output logic                           fib_strobe,
	output ndn_name_t                      fib_name,
	output pit_meta_u                      fib_meta,
	output logic                           fib_miss
);

	route_t           routes [FIB_ENTRIES];
	logic [FIB_ENTRIES-1:0] route_valid;
	logic [FIB_ENTRIES-1:0] hit;

	logic       best_hit;
	logic [6:0] best_len;
	logic [5:0] best_face;

	// Ones in the top len bits
	function automatic logic [63:0] lpm_mask(input logic [6:0] len);
		logic [6:0] sh;
		sh = 7'd64 - len;
		return ~64'd0 << sh;  // A shift of 64 leaves no ones
	endfunction

	// Compare the name against every route at once
	always_comb begin
		for (int i = 0; i < FIB_ENTRIES; i++) begin
			hit[i] = route_valid[i] &&
				(((data_name.prefix ^ routes[i].prefix) & lpm_mask(routes[i].match_len)) == '0);
		end
	end

	// Longest match wins, strict compare keeps the lowest index on a tie
	always_comb begin
		best_hit  = 1'b0;
		best_len  = '0;
		best_face = '0;
		for (int i = 0; i < FIB_ENTRIES; i++) begin
			if (hit[i] && (!best_hit || routes[i].match_len > best_len)) begin
				best_hit  = 1'b1;
				best_len  = routes[i].match_len;
				best_face = routes[i].face;
			end
		end
	end

	// Route table writes
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			route_valid <= '0;
			for (int i = 0; i < FIB_ENTRIES; i++) begin
				routes[i] <= '0;
			end
		end else if (route_wr) begin
			routes[route_index]      <= route;
			route_valid[route_index] <= 1'b1;
		end
	end

	// Forward or miss, one cycle after the strobe
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fib_strobe <= 1'b0;
			fib_miss   <= 1'b0;
		end else begin
			fib_strobe <= data_strobe && best_hit;
			fib_miss   <= data_strobe && !best_hit;
		end
	end

	always_ff @(posedge clk) begin
		if (data_strobe && best_hit) begin
			fib_name                <= data_name;
			fib_meta.data.forwarded <= 1'b1;
			fib_meta.data.again     <= data_again;
			fib_meta.data.face      <= best_face;
		end
	end

endmodule

/* design/pit_hash_table.sv */
`timescale 1ns/100ps

module pit_hash_table import ndn_pkg::*; #(
	parameter int BLOCK_SIZE = 1
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        interest_strobe,
	input  ndn_name_t   interest_name,
	input  logic        fib_strobe,
	input  ndn_name_t   fib_name,
	input  pit_meta_u   fib_meta,
	input  logic [5:0]  slot,
	output logic [63:0] pre_hash,
	output logic        pit_ready,
	output pit_result_t result,
	output logic        result_valid,
	output logic        rejected,
	output logic        repeat_data
);

	typedef enum logic [1:0] {
		idle,
		hash_wait,
		lookup
	} pit_state_t;

	pit_state_t  state;
	pit_entry_t  pit_mem [64];
	pit_entry_t  cur_entry;
	pit_result_t lookup_result;
	pit_meta_u   req_meta;
	logic        req_is_data;  // Request came from the FIB
	logic [9:0]  addr_cnt;

	assign pit_ready = (state == idle);
	assign cur_entry = pit_mem[slot];

	// Entry reported at the end of a lookup
	always_comb begin
		lookup_result.meta = req_meta;
		if (cur_entry.valid) begin
			lookup_result.data_seen = cur_entry.data_seen | req_is_data;
			lookup_result.addr      = cur_entry.addr;
		end else begin
			lookup_result.data_seen = 1'b0;
			lookup_result.addr      = addr_cnt;  // Fresh row for a new interest
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state        <= idle;
			req_is_data  <= 1'b0;
			addr_cnt     <= '0;
			result_valid <= 1'b0;
			rejected     <= 1'b0;
			repeat_data  <= 1'b0;
			for (int i = 0; i < 64; i++) begin
				pit_mem[i] <= '0;
			end
		end else begin
			result_valid <= 1'b0;
			rejected     <= 1'b0;
			repeat_data  <= 1'b0;
			case (state)
				idle: begin
					// Data wins over a simultaneous interest
					if (fib_strobe) begin
						req_is_data <= 1'b1;
						state       <= hash_wait;
					end else if (interest_strobe) begin
						req_is_data <= 1'b0;
						state       <= hash_wait;
					end
				end
				hash_wait: state <= lookup;  // name_hash registers slot here
				lookup: begin
					state <= idle;
					if (cur_entry.valid) begin
						result_valid <= 1'b1;
						if (req_is_data) begin
							repeat_data <= req_meta.data.again && cur_entry.data_seen;
							pit_mem[slot].data_seen <= 1'b1;
						end
					end else if (req_is_data) begin
						rejected <= 1'b1;  // Nobody asked for this data
					end else begin
						result_valid           <= 1'b1;
						pit_mem[slot].valid     <= 1'b1;
						pit_mem[slot].data_seen <= 1'b0;
						pit_mem[slot].addr      <= addr_cnt;
						addr_cnt               <= addr_cnt + 10'(BLOCK_SIZE);
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// Request payload and reported entry
	always_ff @(posedge clk) begin
		if (state == idle) begin
			if (fib_strobe) begin
				pre_hash <= fib_name.prefix;
				req_meta <= fib_meta;
			end else if (interest_strobe) begin
				pre_hash                <= interest_name.prefix;
				req_meta.interest.kind   <= KIND_INTEREST;
				req_meta.interest.length <= interest_name.length;
			end
		end
		if (state == lookup) begin
			result <= lookup_result;
		end
	end

endmodule

/* design/ndn_forwarder_top.sv */
`timescale 1ns/100ps

module ndn_forwarder_top import ndn_pkg::*; #(
	parameter int BLOCK_SIZE  = 1,
	parameter int FIB_ENTRIES = 8
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           interest_strobe,
	input  ndn_name_t                      interest_name,
	input  logic                           route_wr,
	input  logic [$clog2(FIB_ENTRIES)-1:0] route_index,
	input  route_t                         route,
	input  logic                           data_strobe,
	input  ndn_name_t                      data_name,
	input  logic                           data_again,
	output logic                           pit_ready,
	output pit_result_t                    result,
	output logic                           result_valid,
	output logic                           rejected,
	output logic                           repeat_data,
	output logic                           fib_miss
);

	logic        fib_strobe;
	ndn_name_t   fib_name;
	pit_meta_u   fib_meta;
	logic [63:0] pre_hash;
	logic [5:0]  slot;

	// Data from the network goes through the FIB first
	fib_table #(
		.FIB_ENTRIES(FIB_ENTRIES)
	) fib_table_inst (
		.clk        (clk),
		.rst        (rst),
		.route_wr   (route_wr),
		.route_index(route_index),
		.route      (route),
		.data_strobe(data_strobe),
		.data_name  (data_name),
		.data_again (data_again),
		.fib_strobe (fib_strobe),
		.fib_name   (fib_name),
		.fib_meta   (fib_meta),
		.fib_miss   (fib_miss)
	);

	pit_hash_table #(
		.BLOCK_SIZE(BLOCK_SIZE)
	) pit_hash_table_inst (
		.clk            (clk),
		.rst            (rst),
		.interest_strobe(interest_strobe),
		.interest_name  (interest_name),
		.fib_strobe     (fib_strobe),
		.fib_name       (fib_name),
		.fib_meta       (fib_meta),
		.slot           (slot),
		.pre_hash       (pre_hash),
		.pit_ready      (pit_ready),
		.result         (result),
		.result_valid   (result_valid),
		.rejected       (rejected),
		.repeat_data    (repeat_data)
	);

	name_hash name_hash_inst (
		.clk     (clk),
		.rst     (rst),
		.pre_hash(pre_hash),
		.slot    (slot)
	);

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter int RESET_CYCLES = 16
) (
	input  logic reset_req,  // Extra reset on top of power-on
	output logic clk,
	output logic rst
);

	logic por = 1'b1;

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		repeat (RESET_CYCLES) @(posedge clk);
		por <= 1'b0;
	end

	assign rst = por | reset_req;

endmodule

/* sim/ndn_forwarder_tb.sv */
`timescale 1ns/100ps

module ndn_forwarder_tb import ndn_pkg::*; ();

	localparam int FIB_ENTRIES     = 8;
	localparam int BLOCK_SIZE      = 1;
	localparam int RESET_CYCLES    = 16;
	localparam int NUM_REQUESTS    = 22;  // Interests, data and route writes
	localparam int WATCHDOG_CYCLES = NUM_REQUESTS * 10 + 2 * RESET_CYCLES;

	// Expected DUT outputs at one sampling edge
	typedef struct packed {
		logic        pit_busy;  // pit_ready expected low
		logic        result_valid;
		logic        rejected;
		logic        repeat_data;
		logic        fib_miss;
		pit_result_t res;
	} expect_t;

	logic        clk;
	logic        rst;
	logic        reset_req;
	logic        interest_strobe;
	ndn_name_t   interest_name;
	logic        route_wr;
	logic [2:0]  route_index;
	route_t      route;
	logic        data_strobe;
	ndn_name_t   data_name;
	logic        data_again;
	logic        pit_ready;
	pit_result_t result;
	logic        result_valid;
	logic        rejected;
	logic        repeat_data;
	logic        fib_miss;

	logic [7:0]  cyc = 8'd0;
	expect_t     exp_mem [256];  // Indexed by the cycle the output is sampled
	expect_t     exp_now;
	int          error_count = 0;
	int          errors_before;
	int          test_count;
	int          failed_tests;
	logic [31:0] lfsr_state;
	logic [63:0] pfx [4];

	// Reference model state
	pit_entry_t  model_pit [64];
	logic [9:0]  model_cnt;
	route_t      model_route [FIB_ENTRIES];
	logic        model_route_ok [FIB_ENTRIES];

	tb_clock_gen #(
		.RESET_CYCLES(RESET_CYCLES)
	) tb_clock_gen_inst (
		.reset_req(reset_req),
		.clk      (clk),
		.rst      (rst)
	);

	ndn_forwarder_top ndn_forwarder_top_inst (
		.clk            (clk),
		.rst            (rst),
		.interest_strobe(interest_strobe),
		.interest_name  (interest_name),
		.route_wr       (route_wr),
		.route_index    (route_index),
		.route          (route),
		.data_strobe    (data_strobe),
		.data_name      (data_name),
		.data_again     (data_again),
		.pit_ready      (pit_ready),
		.result         (result),
		.result_valid   (result_valid),
		.rejected       (rejected),
		.repeat_data    (repeat_data),
		.fib_miss       (fib_miss)
	);

	always @(posedge clk) cyc <= cyc + 8'd1;
	assign exp_now = exp_mem[cyc];

	task automatic pulse_error(input string name, input logic got);
		error_count++;
		if (got) begin
			$display("Unexpected %s pulse at %0t", name, $time);
		end else begin
			$display("Missing %s pulse at %0t", name, $time);
		end
	endtask

	task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
		error_count++;
		$display("[FAIL] %s got %h expected %h", name, got, exp);
	endtask

	assert property (@(posedge clk) disable iff (rst) pit_ready == !exp_now.pit_busy)
		else value_error("pit_ready", 32'($sampled(pit_ready)),
			32'(!$sampled(exp_now.pit_busy)));
	assert property (@(posedge clk) disable iff (rst) result_valid == exp_now.result_valid)
		else pulse_error("result_valid", $sampled(result_valid));
	assert property (@(posedge clk) disable iff (rst) rejected == exp_now.rejected)
		else pulse_error("rejected", $sampled(rejected));
	assert property (@(posedge clk) disable iff (rst) repeat_data == exp_now.repeat_data)
		else pulse_error("repeat_data", $sampled(repeat_data));
	assert property (@(posedge clk) disable iff (rst) fib_miss == exp_now.fib_miss)
		else pulse_error("fib_miss", $sampled(fib_miss));
	assert property (@(posedge clk) disable iff (rst)
		result_valid && exp_now.result_valid |-> result.addr == exp_now.res.addr)
		else value_error("result.addr", 32'($sampled(result.addr)),
			32'($sampled(exp_now.res.addr)));
	assert property (@(posedge clk) disable iff (rst)
		result_valid && exp_now.result_valid |-> result.data_seen == exp_now.res.data_seen)
		else value_error("result.data_seen", 32'($sampled(result.data_seen)),
			32'($sampled(exp_now.res.data_seen)));
	assert property (@(posedge clk) disable iff (rst)
		result_valid && exp_now.result_valid |-> result.meta == exp_now.res.meta)
		else value_error("result.meta", 32'($sampled(result.meta)),
			32'($sampled(exp_now.res.meta)));

	// Galois form with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic rand_prefix(output logic [63:0] p);
		p = '0;
		for (int b = 0; b < 64; b++) begin
			p = {lfsr_state[0], p[63:1]};  // One step per bit
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic logic [5:0] fold_prefix(input logic [63:0] p);
		logic [5:0] h;
		h = {2'b00, p[63:60]};
		for (int k = 0; k < 10; k++) begin
			h = h ^ p[6*k +: 6];
		end
		return h;
	endfunction

	// A length of 0 matches anything
	function automatic logic prefix_match(input logic [63:0] name, input route_t r);
		return (name >> (64 - int'(r.match_len))) == (r.prefix >> (64 - int'(r.match_len)));
	endfunction

	task automatic find_route(input logic [63:0] name, output logic found,
			output logic [5:0] face);
		logic [6:0] best_len;
		found    = 1'b0;
		face     = '0;
		best_len = '0;
		for (int i = 0; i < FIB_ENTRIES; i++) begin
			if (model_route_ok[i] && prefix_match(name, model_route[i]) &&
					(!found || model_route[i].match_len > best_len)) begin
				found    = 1'b1;
				best_len = model_route[i].match_len;
				face     = model_route[i].face;
			end
		end
	endtask

	task automatic free_prefix(output logic [63:0] p);
		rand_prefix(p);
		while (model_pit[fold_prefix(p)].valid) begin
			rand_prefix(p);
		end
	endtask

	task automatic wait_ready(output logic [7:0] base);
		@(posedge clk);
		while (!pit_ready) begin
			@(posedge clk);
		end
		base = cyc;  // Value before this edge
	endtask

	task automatic post_expect(input logic [7:0] base, input logic [7:0] delay, input expect_t e);
		exp_mem[base + delay] <= e;
	endtask

	task automatic finish_request(input logic [7:0] base);
		@(posedge clk);
		interest_strobe <= 1'b0;
		data_strobe     <= 1'b0;
		repeat (5) @(posedge clk);
		for (int k = 1; k <= 6; k++) begin
			exp_mem[base + 8'(k)] <= '0;  // Window fully checked by now
		end
	endtask

	task automatic send_interest(input logic [63:0] prefix, input logic [5:0] len);
		logic [7:0] base;
		logic [5:0] s;
		expect_t    e;
		expect_t    busy_e;
		e               = '0;
		busy_e          = '0;
		busy_e.pit_busy = 1'b1;
		s = fold_prefix(prefix);
		e.result_valid              = 1'b1;
		e.res.meta.interest.kind   = KIND_INTEREST;
		e.res.meta.interest.length = len;
		if (model_pit[s].valid) begin
			e.res.data_seen = model_pit[s].data_seen;
			e.res.addr      = model_pit[s].addr;
		end else begin
			e.res.addr              = model_cnt;
			model_pit[s].valid     = 1'b1;
			model_pit[s].data_seen = 1'b0;
			model_pit[s].addr      = model_cnt;
			model_cnt              = model_cnt + 10'(BLOCK_SIZE);
		end
		wait_ready(base);
		interest_strobe <= 1'b1;
		interest_name   <= {prefix, len};
		post_expect(base, 8'd2, busy_e);  // PIT leaves idle for two cycles
		post_expect(base, 8'd3, busy_e);
		post_expect(base, 8'd4, e);  // Outcome registers 3 edges after the drive edge
		finish_request(base);
	endtask

	task automatic send_data(input logic [63:0] prefix, input logic [5:0] len, input logic again);
		logic [7:0] base;
		logic       found;
		logic [5:0] face;
		logic [5:0] s;
		expect_t    miss_e;
		expect_t    pit_e;
		expect_t    busy_e;
		miss_e          = '0;
		pit_e           = '0;
		busy_e          = '0;
		busy_e.pit_busy = 1'b1;
		s      = fold_prefix(prefix);
		find_route(prefix, found, face);
		if (!found) begin
			miss_e.fib_miss = 1'b1;
		end else if (!model_pit[s].valid) begin
			pit_e.rejected = 1'b1;
		end else begin
			pit_e.result_valid            = 1'b1;
			pit_e.repeat_data             = again && model_pit[s].data_seen;
			pit_e.res.data_seen           = 1'b1;
			pit_e.res.addr                = model_pit[s].addr;
			pit_e.res.meta.data.forwarded = 1'b1;
			pit_e.res.meta.data.again     = again;
			pit_e.res.meta.data.face      = face;
			model_pit[s].data_seen        = 1'b1;
		end
		wait_ready(base);
		data_strobe <= 1'b1;
		data_name   <= {prefix, len};
		data_again  <= again;
		post_expect(base, 8'd2, miss_e);
		if (found) begin
			post_expect(base, 8'd3, busy_e);
			post_expect(base, 8'd4, busy_e);
		end
		post_expect(base, 8'd5, pit_e);  // One extra edge through the FIB
		finish_request(base);
	endtask

	task automatic write_route(input logic [2:0] idx, input logic [63:0] prefix,
			input logic [6:0] len, input logic [5:0] face);
		route_t r;
		r.prefix    = prefix;
		r.match_len = len;
		r.face      = face;
		@(posedge clk);
		route_wr    <= 1'b1;
		route_index <= idx;
		route       <= r;
		@(posedge clk);
		route_wr    <= 1'b0;
		model_route[idx]    = r;
		model_route_ok[idx] = 1'b1;
	endtask

	task automatic clear_model();
		for (int i = 0; i < 64; i++) begin
			model_pit[i] = '0;
		end
		for (int i = 0; i < FIB_ENTRIES; i++) begin
			model_route_ok[i] = 1'b0;
		end
		model_cnt = '0;
	endtask

	task automatic start_test();
		errors_before = error_count;
	endtask

	task automatic report_test(input string name);
		test_count++;
		if (error_count != errors_before) begin
			failed_tests++;
			$display("test %0d %s: %0d errors", test_count, name, error_count - errors_before);
		end else begin
			$display("test %0d %s: ok", test_count, name);
		end
	endtask

	initial begin
		logic [63:0] q;
		interest_strobe <= 1'b0;
		interest_name   <= '0;
		route_wr        <= 1'b0;
		route_index     <= '0;
		route           <= '0;
		data_strobe     <= 1'b0;
		data_name       <= '0;
		data_again      <= 1'b0;
		reset_req       <= 1'b0;
		for (int i = 0; i < 256; i++) begin
			exp_mem[i] <= '0;
		end
		lfsr_state   = 32'ha6bf48e5;
		test_count   = 0;
		failed_tests = 0;
		clear_model();
		@(negedge rst);

		start_test();
		free_prefix(pfx[0]);
		send_interest(pfx[0], 6'd5);
		free_prefix(pfx[1]);
		send_interest(pfx[1], 6'd12);
		free_prefix(pfx[2]);
		send_interest(pfx[2], 6'd33);
		report_test("new interests");

		start_test();
		send_interest(pfx[1], 6'd12);
		send_interest(pfx[0] ^ 64'h41, 6'd7);  // Flips cancel in the fold
		free_prefix(pfx[3]);
		send_interest(pfx[3], 6'd20);
		report_test("interest hits");

		start_test();
		write_route(3'd0, pfx[0], 7'd16, 6'h05);
		send_data(~pfx[0], 6'd5, 1'b0);
		rand_prefix(q);
		q[63:48] = pfx[0][63:48];
		while (model_pit[fold_prefix(q)].valid) begin
			rand_prefix(q);
			q[63:48] = pfx[0][63:48];
		end
		send_data(q, 6'd9, 1'b0);
		report_test("unrouted and unrequested data");

		start_test();
		write_route(3'd1, pfx[1], 7'd24, 6'h11);
		send_data(pfx[1], 6'd12, 1'b0);
		send_data(pfx[1], 6'd12, 1'b1);
		send_data(pfx[1], 6'd12, 1'b0);
		report_test("data for pending interest");

		start_test();
		write_route(3'd2, pfx[2], 7'd8, 6'h21);
		write_route(3'd3, pfx[2], 7'd40, 6'h2a);
		write_route(3'd4, pfx[2], 7'd40, 6'h33);  // Ties with index 3
		send_data(pfx[2], 6'd33, 1'b0);
		write_route(3'd3, pfx[2], 7'd40, 6'h3c);
		send_data(pfx[2], 6'd33, 1'b1);
		report_test("longest prefix match");

		start_test();
		@(posedge clk);
		reset_req <= 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset_req <= 1'b0;
		clear_model();
		send_interest(pfx[3], 6'd20);
		write_route(3'd0, pfx[1], 7'd64, 6'h09);
		send_data(pfx[1], 6'd12, 1'b0);
		report_test("mid-run reset");

		$display("%0d tests run, %0d failed, %0d errors", test_count, failed_tests, error_count);
		if (error_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

/* filelist.f */
design/ndn_pkg.sv
design/name_hash.sv
design/fib_table.sv
design/pit_hash_table.sv
design/ndn_forwarder_top.sv
sim/tb_clock_gen.sv
sim/ndn_forwarder_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the forwarder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module ndn_forwarder_tb \
	-f filelist.f

output=$(./obj_dir/Vndn_forwarder_tb)
echo "$output"

if echo "$output" | grep -q "Simulation PASSED"; then
	exit 0
else
	echo "Testbench reported a failure"
	exit 1
fi
